// ==== Makefile ====
# Verilator build for the ecc word store testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= ecc_word_store_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hdl/ecc_decoder.sv ====
// ecc_decoder: syndrome, error classification, single-bit correction and response register
`timescale 1ns/1ps

module ecc_decoder (
   input  logic                       clk,
   input  logic                       rst_l,
   input  logic [ecc_pkg::CODE_W-1:0] word,
   input  logic                       word_valid,
   output logic                       rsp_valid,
   output logic [ecc_pkg::DATA_W-1:0] rsp_data,
   output logic                       rsp_single_err,
   output logic                       rsp_double_err
);

   logic [ecc_pkg::DATA_W-1:0] dat;
   logic [ecc_pkg::ECC_W-1:0]  chk;
   logic [ecc_pkg::CODE_W-1:0] pos_vec;     // word in hamming positional order
   logic [ecc_pkg::CODE_W-1:0] err_mask;
   logic [ecc_pkg::CODE_W-1:0] fixed_vec;
   logic [ecc_pkg::HAM_W-1:0]  syndrome;
   logic                       parity_err;
   logic                       single_err;
   logic                       double_err;
   logic [ecc_pkg::DATA_W-1:0] fixed_data;

   assign dat = word[ecc_pkg::DATA_W-1:0];
   assign chk = word[ecc_pkg::CODE_W-1:ecc_pkg::DATA_W];

   // index p-1 holds position p, the top bit holds overall parity
   always_comb begin
      pos_vec = '0;
      for (int k = 0; k < ecc_pkg::HAM_W; k++) begin
         pos_vec[(1 << k) - 1] = chk[k];
      end
      for (int d = 0; d < ecc_pkg::DATA_W; d++) begin
         pos_vec[ecc_pkg::ham_pos(d) - 1] = dat[d];
      end
      pos_vec[ecc_pkg::CODE_W-1] = chk[ecc_pkg::ECC_W-1];
   end

   // syndrome bit k: parity over all positions with bit k set, stored check bit included
   always_comb begin
      syndrome = '0;
      for (int p = 1; p < ecc_pkg::CODE_W; p++) begin
         for (int k = 0; k < ecc_pkg::HAM_W; k++) begin
            if (((p >> k) & 1) == 1) begin
               syndrome[k] = syndrome[k] ^ pos_vec[p - 1];
            end
         end
      end
   end

   assign parity_err = ^word;   // odd weight means an odd number of flips

   // odd count is taken as one flip, even count with nonzero syndrome as two
   assign single_err = parity_err;
   assign double_err = (syndrome != '0) & ~parity_err;

   // syndrome names the flipped position, zero when only the parity bit flipped
   always_comb begin
      for (int i = 0; i < ecc_pkg::CODE_W; i++) begin
         err_mask[i] = (int'(syndrome) == i + 1);
      end
   end

   assign fixed_vec = single_err ? (pos_vec ^ err_mask) : pos_vec;

   always_comb begin
      for (int d = 0; d < ecc_pkg::DATA_W; d++) begin
         fixed_data[d] = fixed_vec[ecc_pkg::ham_pos(d) - 1];
      end
   end

   // response stage, flags only ever set alongside rsp_valid
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rsp_valid      <= 1'b0;
         rsp_single_err <= 1'b0;
         rsp_double_err <= 1'b0;
      end else begin
         rsp_valid      <= word_valid;
         rsp_single_err <= word_valid & single_err;
         rsp_double_err <= word_valid & double_err;
      end
   end

   always_ff @(posedge clk) begin
      if (word_valid) begin
         rsp_data <= fixed_data;
      end
   end

endmodule

// ==== hdl/ecc_encoder.sv ====
// ecc_encoder: secded check-bit generator for one data word
`timescale 1ns/1ps

module ecc_encoder (
   input  logic [ecc_pkg::DATA_W-1:0] data,
   output logic [ecc_pkg::ECC_W-1:0]  ecc
);

   logic [ecc_pkg::HAM_W-1:0] ham;   // hamming check bits

   // check bit k covers every data bit whose hamming position has bit k set
   always_comb begin
      ham = '0;
      for (int d = 0; d < ecc_pkg::DATA_W; d++) begin
         for (int k = 0; k < ecc_pkg::HAM_W; k++) begin
            if (((ecc_pkg::ham_pos(d) >> k) & 1) == 1) begin
               ham[k] = ham[k] ^ data[d];
            end
         end
      end
   end

   // overall parity over data and hamming bits makes the word even
   assign ecc = {(^data) ^ (^ham), ham};

endmodule

// ==== hdl/ecc_pkg.sv ====
// widths, depth, credit count and the data-bit to hamming-position map for the ecc store
package ecc_pkg;

   localparam int DATA_W  = 32;               // data word
   localparam int HAM_W   = 6;                // hamming syndrome bits
   localparam int ECC_W   = HAM_W + 1;        // hamming bits plus overall parity
   localparam int CODE_W  = DATA_W + ECC_W;   // stored codeword, check bits on top
   localparam int DEPTH   = 16;
   localparam int ADDR_W  = 4;
   localparam int CREDITS = 4;                // response credits after reset
   localparam int CRED_W  = 3;

   // position (1..38) of data bit d in hamming order
   // powers of two hold the check bits, data fills the rest in ascending order
   function automatic int ham_pos(input int d);
      int pos;
      int cnt;
      pos = 0;
      cnt = 0;
      for (int p = 3; p < CODE_W; p++) begin
         if ((p & (p - 1)) != 0) begin       // skip check-bit slots
            if (cnt == d) pos = p;
            cnt++;
         end
      end
      return pos;
   endfunction

endpackage

// ==== hdl/ecc_word_array.sv ====
// ecc_word_array: codeword storage with encode on write, error injection and registered read
`timescale 1ns/1ps

module ecc_word_array (
   input  logic                       clk,
   input  logic                       rst_l,
   input  logic                       wr_en,
   input  logic [ecc_pkg::ADDR_W-1:0] wr_addr,
   input  logic [ecc_pkg::DATA_W-1:0] wr_data,
   input  logic [ecc_pkg::CODE_W-1:0] wr_flip,
   input  logic                       rd_accept,
   input  logic [ecc_pkg::ADDR_W-1:0] rd_addr,
   output logic [ecc_pkg::CODE_W-1:0] rd_word,
   output logic                       rd_word_valid
);

   logic [ecc_pkg::CODE_W-1:0] mem [ecc_pkg::DEPTH];
   logic [ecc_pkg::ECC_W-1:0]  wr_ecc;
   logic [ecc_pkg::CODE_W-1:0] wr_word;

   ecc_encoder enc_i (
      .data (wr_data),
      .ecc  (wr_ecc)
   );

   // flip mask lets the test corrupt chosen bits of the stored word
   assign wr_word = {wr_ecc, wr_data} ^ wr_flip;

   // all-zero is a valid codeword, so cleared entries read back clean
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         for (int i = 0; i < ecc_pkg::DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_addr] <= wr_word;
      end
   end

   // a read and write to the same entry on one edge sees the old word
   always_ff @(posedge clk) begin
      if (rd_accept) begin
         rd_word <= mem[rd_addr];
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_word_valid <= 1'b0;
      end else begin
         rd_word_valid <= rd_accept;   // one cycle per accepted read
      end
   end

endmodule

// ==== hdl/ecc_word_store.sv ====
// ecc_word_store: top level of the secded word store with credit-gated reads
`timescale 1ns/1ps

module ecc_word_store (
   input  logic                       clk,
   input  logic                       rst_l,

   // write port, no back-pressure
   input  logic                       wr_en,
   input  logic [ecc_pkg::ADDR_W-1:0] wr_addr,
   input  logic [ecc_pkg::DATA_W-1:0] wr_data,
   input  logic [ecc_pkg::CODE_W-1:0] wr_flip,

   // read request
   input  logic                       rd_valid,
   input  logic [ecc_pkg::ADDR_W-1:0] rd_addr,
   output logic                       rd_ready,

   // response, two cycles after accept
   output logic                       rsp_valid,
   output logic [ecc_pkg::DATA_W-1:0] rsp_data,
   output logic                       rsp_single_err,
   output logic                       rsp_double_err,

   input  logic                       credit_return
);

   logic                       rd_accept;
   logic [ecc_pkg::CODE_W-1:0] rd_word;
   logic                       rd_word_valid;

   rsp_credit_ctrl credit_i (
      .clk           (clk),
      .rst_l         (rst_l),
      .rd_valid      (rd_valid),
      .credit_return (credit_return),
      .rd_ready      (rd_ready),
      .rd_accept     (rd_accept)
   );

   ecc_word_array array_i (
      .clk           (clk),
      .rst_l         (rst_l),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .wr_flip       (wr_flip),
      .rd_accept     (rd_accept),
      .rd_addr       (rd_addr),
      .rd_word       (rd_word),
      .rd_word_valid (rd_word_valid)
   );

   ecc_decoder decoder_i (
      .clk            (clk),
      .rst_l          (rst_l),
      .word           (rd_word),
      .word_valid     (rd_word_valid),
      .rsp_valid      (rsp_valid),
      .rsp_data       (rsp_data),
      .rsp_single_err (rsp_single_err),
      .rsp_double_err (rsp_double_err)
   );

endmodule

// ==== hdl/rsp_credit_ctrl.sv ====
// rsp_credit_ctrl: response credit counter and read accept gating
`timescale 1ns/1ps

module rsp_credit_ctrl (
   input  logic clk,
   input  logic rst_l,
   input  logic rd_valid,
   input  logic credit_return,
   output logic rd_ready,
   output logic rd_accept
);

   logic [ecc_pkg::CRED_W-1:0] credits;   // responses the consumer can still take

   // ready straight from the registered count
   assign rd_ready  = (credits != '0);
   assign rd_accept = rd_valid & rd_ready;

   // consumer never returns more than it holds, so no overflow guard
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         credits <= ecc_pkg::CRED_W'(ecc_pkg::CREDITS);
      end else begin
         case ({rd_accept, credit_return})
            2'b10:   credits <= credits - 1'b1;   // spent on a read
            2'b01:   credits <= credits + 1'b1;   // handed back
            default: credits <= credits;          // none, or both cancel
         endcase
      end
   end

endmodule

// ==== list.f ====
hdl/ecc_pkg.sv
hdl/ecc_encoder.sv
hdl/ecc_word_array.sv
hdl/ecc_decoder.sv
hdl/rsp_credit_ctrl.sv
hdl/ecc_word_store.sv
test/ecc_word_store_sva.sv
test/ecc_word_store_tb.sv

// ==== test/ecc_word_store_sva.sv ====
// ecc_word_store_sva: protocol and timing assertions bound to the word store top level
`timescale 1ns/1ps

module ecc_word_store_sva (
   input logic clk,
   input logic rst_l,
   input logic rd_valid,
   input logic rd_ready,
   input logic rd_accept,
   input logic rsp_valid,
   input logic rsp_single_err,
   input logic rsp_double_err
);

   // response lands exactly two edges after the accept
   a_rsp_after_accept: assert property (@(posedge clk) disable iff (!rst_l)
      rd_accept |-> ##2 rsp_valid)
      else $error("response missing two cycles after accept");

   a_rsp_has_accept: assert property (@(posedge clk) disable iff (!rst_l)
      rsp_valid |-> $past(rd_accept, 2))
      else $error("response without an accept two cycles earlier");

   a_ready_after_reset: assert property (@(posedge clk)
      $rose(rst_l) |-> rd_ready)
      else $error("rd_ready low right after reset");

   a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_l)
      !(rsp_single_err && rsp_double_err))
      else $error("single and double error flags both set");

   a_flags_idle: assert property (@(posedge clk) disable iff (!rst_l)
      !rsp_valid |-> (!rsp_single_err && !rsp_double_err))
      else $error("error flag set without rsp_valid");

   // a request held off by rd_ready must not turn into a response
   a_no_accept_blocked: assert property (@(posedge clk) disable iff (!rst_l)
      rd_valid && !rd_ready |-> ##2 !rsp_valid)
      else $error("response for a read offered while rd_ready low");

endmodule

bind ecc_word_store ecc_word_store_sva sva_i (.*);

// ==== test/ecc_word_store_tb.sv ====
// ecc_word_store_tb: clock, reset, lfsr stimulus, expectation fifo, checking assertions, watchdog
`timescale 1ns/1ps

module ecc_word_store_tb;

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 5;
   localparam int N_CLEAN    = 16;
   localparam int N_DOUBLE   = 8;
   localparam int N_PIPE     = 12;
   localparam int N_TRANS    = 2 * N_CLEAN + 2 * ecc_pkg::CODE_W + 2 * N_DOUBLE
                               + 2 * ecc_pkg::CREDITS + N_PIPE + 4;
   localparam int CYC_PER_TRANS = 4;   // reads may wait on credits
   localparam int WATCHDOG_NS   = (N_TRANS * CYC_PER_TRANS + 100) * CLK_PERIOD;

   logic                       clk = 1'b0;
   logic                       rst_l;
   logic                       wr_en;
   logic [ecc_pkg::ADDR_W-1:0] wr_addr;
   logic [ecc_pkg::DATA_W-1:0] wr_data;
   logic [ecc_pkg::CODE_W-1:0] wr_flip;
   logic                       rd_valid;
   logic [ecc_pkg::ADDR_W-1:0] rd_addr;
   logic                       rd_ready;
   logic                       rsp_valid;
   logic [ecc_pkg::DATA_W-1:0] rsp_data;
   logic                       rsp_single_err;
   logic                       rsp_double_err;
   logic                       credit_return = 1'b0;

   logic [31:0] lfsr = 32'h89d910a8;
   logic        auto_return;
   logic        ret_coin = 1'b0;      // random bit for the consumer
   int          fail_cnt = 0;
   int          checked_cnt;
   int          acc_cnt;
   int          held;                 // responses taken, credit not yet given back
   int          tb_cred;              // credit count as the consumer sees it

   // shadow of the store
   logic [ecc_pkg::DATA_W-1:0] shadow_data [ecc_pkg::DEPTH];
   int                         shadow_flips [ecc_pkg::DEPTH];

   // expectations in accept order
   logic [ecc_pkg::DATA_W-1:0] exp_data_mem [16];
   logic [1:0]                 exp_cls_mem [16];
   logic [3:0]                 wptr;
   logic [3:0]                 rptr;
   int                         exp_cnt;
   logic [ecc_pkg::DATA_W-1:0] exp_data;
   logic [1:0]                 exp_cls;   // 0 clean, 1 single, 2 double

   assign exp_data = exp_data_mem[rptr];
   assign exp_cls  = exp_cls_mem[rptr];

   ecc_word_store dut_i (
      .clk            (clk),
      .rst_l          (rst_l),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .wr_flip        (wr_flip),
      .rd_valid       (rd_valid),
      .rd_addr        (rd_addr),
      .rd_ready       (rd_ready),
      .rsp_valid      (rsp_valid),
      .rsp_data       (rsp_data),
      .rsp_single_err (rsp_single_err),
      .rsp_double_err (rsp_double_err),
      .credit_return  (credit_return)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic        fb;
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [1:0] err_class(input int flips);
      if (flips == 0) return 2'd0;
      if (flips == 1) return 2'd1;
      return 2'd2;
   endfunction

   // model of store contents, expectation fifo and credits
   always @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         for (int i = 0; i < ecc_pkg::DEPTH; i++) begin
            shadow_data[i]  <= '0;
            shadow_flips[i] <= 0;
         end
         wptr        <= '0;
         rptr        <= '0;
         exp_cnt     <= 0;
         checked_cnt <= 0;
         acc_cnt     <= 0;
         tb_cred     <= ecc_pkg::CREDITS;
      end else begin
         if (wr_en) begin
            shadow_data[wr_addr]  <= wr_data;
            shadow_flips[wr_addr] <= $countones(wr_flip);
         end
         if (rd_valid && rd_ready) begin   // old contents on a same-edge write
            exp_data_mem[wptr] <= shadow_data[rd_addr];
            exp_cls_mem[wptr]  <= err_class(shadow_flips[rd_addr]);
            wptr    <= wptr + 1'b1;
            acc_cnt <= acc_cnt + 1;
         end
         if (rsp_valid) begin
            rptr        <= rptr + 1'b1;
            checked_cnt <= checked_cnt + 1;
         end
         exp_cnt <= exp_cnt + int'(rd_valid && rd_ready) - int'(rsp_valid);
         tb_cred <= tb_cred - int'(rd_valid && rd_ready) + int'(credit_return);
      end
   end

   // drawn between edges, away from the stimulus draws
   always @(negedge clk) begin
      ret_coin = 1'(take_bits(1));
   end

   // consumer hands credits back at random times
   always @(posedge clk or negedge rst_l) begin : consumer
      int h;
      if (!rst_l) begin
         held          <= 0;
         credit_return <= 1'b0;
      end else begin
         h = held + int'(rsp_valid);
         if (auto_return && h > 0 && ret_coin) begin
            credit_return <= 1'b1;
            h = h - 1;
         end else begin
            credit_return <= 1'b0;
         end
         held <= h;
      end
   end

   a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_l)
      rsp_valid |-> exp_cnt > 0)
      else begin
         $display("response arrived at %0t with no read outstanding", $time);
         fail_cnt++;
      end

   // data of a double error is not defined
   a_rsp_data: assert property (@(posedge clk) disable iff (!rst_l)
      rsp_valid && exp_cls != 2'd2 |-> rsp_data == exp_data)
      else begin
         $display("FAILED %0t rsp_data expected %h got %h", $time,
                  $sampled(exp_data), $sampled(rsp_data));
         fail_cnt++;
      end

   a_rsp_single: assert property (@(posedge clk) disable iff (!rst_l)
      rsp_valid |-> rsp_single_err == (exp_cls == 2'd1))
      else begin
         $display("FAILED %0t rsp_single_err expected %b got %b", $time,
                  $sampled(exp_cls) == 2'd1, $sampled(rsp_single_err));
         fail_cnt++;
      end

   a_rsp_double: assert property (@(posedge clk) disable iff (!rst_l)
      rsp_valid |-> rsp_double_err == (exp_cls == 2'd2))
      else begin
         $display("FAILED %0t rsp_double_err expected %b got %b", $time,
                  $sampled(exp_cls) == 2'd2, $sampled(rsp_double_err));
         fail_cnt++;
      end

   a_rd_ready: assert property (@(posedge clk) disable iff (!rst_l)
      rd_ready == (tb_cred != 0))
      else begin
         $display("FAILED %0t rd_ready expected %b got %b", $time,
                  $sampled(tb_cred) != 0, $sampled(rd_ready));
         fail_cnt++;
      end

   task automatic do_write(input logic [ecc_pkg::ADDR_W-1:0] a,
                           input logic [ecc_pkg::DATA_W-1:0] d,
                           input logic [ecc_pkg::CODE_W-1:0] f);
      wr_en   <= 1'b1;
      wr_addr <= a;
      wr_data <= d;
      wr_flip <= f;
      @(posedge clk);
      wr_en   <= 1'b0;
      wr_flip <= '0;
   endtask

   // leaves rd_valid high so reads can go back to back
   task automatic do_read(input logic [ecc_pkg::ADDR_W-1:0] a);
      rd_valid <= 1'b1;
      rd_addr  <= a;
      @(posedge clk);
      while (!rd_ready) @(posedge clk);
   endtask

   task automatic drain();
      rd_valid <= 1'b0;
      @(posedge clk);
      while (exp_cnt != 0) @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   task automatic report_test(input string name);
      $display("test %s done at %0t, %0d responses checked, %0d failures so far",
               name, $time, checked_cnt, fail_cnt);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired at %0t, the run did not complete", $time);
      $display("Simulation failed");
      $finish;
   end

   initial begin : stimulus
      logic [31:0]                v;
      logic [31:0]                a;
      logic [ecc_pkg::CODE_W-1:0] f;
      int                         p1;
      int                         p2;
      int                         acc_start;
      rst_l         = 1'b0;
      wr_en         = 1'b0;
      wr_addr       = '0;
      wr_data       = '0;
      wr_flip       = '0;
      rd_valid      = 1'b0;
      rd_addr       = '0;
      auto_return   = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst_l <= 1'b1;
      @(posedge clk);

      // clean writes then reads
      for (int i = 0; i < N_CLEAN; i++) begin
         v = take_bits(32);
         do_write(i[ecc_pkg::ADDR_W-1:0], v, '0);
      end
      for (int i = 0; i < N_CLEAN; i++) begin
         do_read(i[ecc_pkg::ADDR_W-1:0]);
      end
      drain();
      report_test("clean_read");

      // one flipped bit at each codeword position
      for (int b = 0; b < ecc_pkg::CODE_W; b++) begin
         a    = take_bits(ecc_pkg::ADDR_W);
         v    = take_bits(32);
         f    = '0;
         f[b] = 1'b1;
         do_write(a[ecc_pkg::ADDR_W-1:0], v, f);
         do_read(a[ecc_pkg::ADDR_W-1:0]);
         rd_valid <= 1'b0;
      end
      drain();
      report_test("single_error");

      for (int i = 0; i < N_DOUBLE; i++) begin
         a  = take_bits(ecc_pkg::ADDR_W);
         v  = take_bits(32);
         p1 = int'(take_bits(6)) % ecc_pkg::CODE_W;
         p2 = p1;
         while (p2 == p1) begin
            p2 = int'(take_bits(6)) % ecc_pkg::CODE_W;
         end
         f     = '0;
         f[p1] = 1'b1;
         f[p2] = 1'b1;
         do_write(a[ecc_pkg::ADDR_W-1:0], v, f);
         do_read(a[ecc_pkg::ADDR_W-1:0]);
         rd_valid <= 1'b0;
      end
      drain();
      report_test("double_error");

      // all credits home, then hold them back
      while (tb_cred != ecc_pkg::CREDITS) @(posedge clk);
      auto_return <= 1'b0;
      @(posedge clk);
      acc_start = acc_cnt;
      rd_valid <= 1'b1;
      rd_addr  <= '0;
      repeat (3 * ecc_pkg::CREDITS) @(posedge clk);
      a_credit_hold: assert (acc_cnt - acc_start == ecc_pkg::CREDITS)
         else begin
            $display("%0d reads accepted without credit returns, %0d expected",
                     acc_cnt - acc_start, ecc_pkg::CREDITS);
            fail_cnt++;
         end
      auto_return <= 1'b1;   // returns reopen rd_ready
      while (acc_cnt - acc_start < 2 * ecc_pkg::CREDITS) @(posedge clk);
      drain();
      report_test("credit_backpressure");

      // back to back reads over the written entries
      for (int i = 0; i < N_PIPE; i++) begin
         do_read(i[ecc_pkg::ADDR_W-1:0]);
      end
      drain();
      report_test("pipelined_read");

      $display("closing: %0d responses checked, %0d failures", checked_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
